// ==== hdl/csr_arch_pkg.sv ====
package csr_arch_pkg;

    // ****************************************
    // Register width.
    // ****************************************
    localparam int XLEN = 64;

    // ****************************************
    // Machine-mode CSR addresses.
    // ****************************************
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // ****************************************
    // mstatus fields.
    // ****************************************
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11; // MPP spans two bits from here.

    // UXL/SXL fixed at 64 bits, MPP at M.
    localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h0000_0000_a000_1800;

endpackage

// ==== hdl/csr_ctrl_pkg.sv ====
package csr_ctrl_pkg;

    // Bit 2 marks the immediate forms, bits 1:0 the modify kind.
    typedef enum logic [3:0] {
        OP_CSRRW  = 4'b0001,
        OP_CSRRS  = 4'b0010,
        OP_CSRRC  = 4'b0011,
        OP_CSRRWI = 4'b0101,
        OP_CSRRSI = 4'b0110,
        OP_CSRRCI = 4'b0111,
        OP_TRAP   = 4'b1000,
        OP_MRET   = 4'b1001
    } csr_op_e;

    // What the addressed hart does.
    typedef enum logic [2:0] {
        KIND_NONE  = 3'd0,
        KIND_WRITE = 3'd1,
        KIND_SET   = 3'd2,
        KIND_CLEAR = 3'd3,
        KIND_TRAP  = 3'd4,
        KIND_RET   = 3'd5
    } csr_kind_e;

endpackage

// ==== hdl/csr_req_if.sv ====
`timescale 1ns/10ps

interface csr_req_if
    import csr_arch_pkg::*;
    import csr_ctrl_pkg::*;
();

    logic            sel;     // Hart addressed this cycle.
    csr_kind_e       kind;
    logic [11:0]     addr;
    logic [XLEN-1:0] operand; // rs1 or zero-extended zimm.
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] pc;

    modport source (
        output sel,
        output kind,
        output addr,
        output operand,
        output cause,
        output pc
    );

    modport sink (
        input sel,
        input kind,
        input addr,
        input operand,
        input cause,
        input pc
    );

endinterface

// ==== hdl/csr_rsp_if.sv ====
`timescale 1ns/10ps

interface csr_rsp_if
    import csr_arch_pkg::*;
();

    logic [XLEN-1:0] rd_data; // Old CSR value, zero otherwise.
    logic            err;
    logic            jmp;
    logic [XLEN-1:0] nxtpc;

    modport source (
        output rd_data,
        output err,
        output jmp,
        output nxtpc
    );

    modport sink (
        input rd_data,
        input err,
        input jmp,
        input nxtpc
    );

endinterface

// ==== hdl/csr_dispatch.sv ====
`timescale 1ns/10ps

module csr_dispatch
    import csr_arch_pkg::*;
    import csr_ctrl_pkg::*;
#(
    parameter int NUM_HARTS = 4,
    localparam int HART_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
    input  logic              valid,
    input  csr_op_e           op,
    input  logic [7:0]        hart,
    input  logic [11:0]       addr,
    input  logic [XLEN-1:0]   rs1,
    input  logic [4:0]        zimm,
    input  logic [XLEN-1:0]   cause,
    input  logic [XLEN-1:0]   pc,
    csr_req_if.source         req [NUM_HARTS],
    output logic [HART_W-1:0] hart_sel,
    output logic              bad_hart,
    output logic              req_fire
);

    csr_kind_e       kind;
    logic            is_imm;
    logic            in_range;
    logic [XLEN-1:0] operand;

    // ****************************************
    // Opcode decode.
    // ****************************************
    always_comb begin
        case (op)
            OP_CSRRW, OP_CSRRWI: kind = KIND_WRITE;
            OP_CSRRS, OP_CSRRSI: kind = KIND_SET;
            OP_CSRRC, OP_CSRRCI: kind = KIND_CLEAR;
            OP_TRAP:             kind = KIND_TRAP;
            OP_MRET:             kind = KIND_RET;
            default:             kind = KIND_NONE;
        endcase
    end

    assign is_imm  = op inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
    assign operand = is_imm ? {{(XLEN-5){1'b0}}, zimm} : rs1;

    // Hart index check.
    assign in_range = hart < NUM_HARTS;
    assign bad_hart = valid && !in_range;
    assign hart_sel = hart[HART_W-1:0];
    assign req_fire = valid;

    // ****************************************
    // Per-hart requests.
    // ****************************************
    for (genvar g = 0; g < NUM_HARTS; g++) begin : g_req
        assign req[g].sel     = valid && in_range && (hart_sel == HART_W'(g));
        assign req[g].kind    = kind;
        assign req[g].addr    = addr;
        assign req[g].operand = operand;
        assign req[g].cause   = cause;
        assign req[g].pc      = pc;
    end

endmodule

// ==== hdl/hart_csr.sv ====
`timescale 1ns/10ps

module hart_csr
    import csr_arch_pkg::*;
    import csr_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    csr_req_if.sink   req,
    csr_rsp_if.source rsp
);

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtvec;

    logic [XLEN-1:0] mstatus_nxt;
    logic [XLEN-1:0] mepc_nxt;
    logic [XLEN-1:0] mcause_nxt;
    logic [XLEN-1:0] mtvec_nxt;

    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic            known;
    logic            csr_kind;

    // ****************************************
    // Read mux.
    // ****************************************
    always_comb begin
        known = 1'b1;
        case (req.addr)
            CSR_MSTATUS: old_val = mstatus;
            CSR_MEPC:    old_val = mepc;
            CSR_MCAUSE:  old_val = mcause;
            CSR_MTVEC:   old_val = mtvec;
            default: begin
                old_val = '0;
                known   = 1'b0;
            end
        endcase
    end

    assign csr_kind = req.kind inside {KIND_WRITE, KIND_SET, KIND_CLEAR};

    // Modify unit.
    always_comb begin
        case (req.kind)
            KIND_WRITE: new_val = req.operand;
            KIND_SET:   new_val = old_val | req.operand;
            KIND_CLEAR: new_val = old_val & ~req.operand;
            default:    new_val = old_val;
        endcase
    end

    // ****************************************
    // Next state.
    // ****************************************
    always_comb begin
        mstatus_nxt = mstatus;
        mepc_nxt    = mepc;
        mcause_nxt  = mcause;
        mtvec_nxt   = mtvec;
        if (req.sel) begin
            case (req.kind)
                KIND_WRITE, KIND_SET, KIND_CLEAR: begin
                    case (req.addr) // Unknown address writes nothing.
                        CSR_MSTATUS: mstatus_nxt = new_val;
                        CSR_MEPC:    mepc_nxt    = new_val;
                        CSR_MCAUSE:  mcause_nxt  = new_val;
                        CSR_MTVEC:   mtvec_nxt   = new_val;
                        default:     ;
                    endcase
                end
                KIND_TRAP: begin
                    mcause_nxt = req.cause;
                    mepc_nxt   = req.pc;
                    mstatus_nxt[MSTATUS_MPP_LO +: 2] = 2'b11;
                    mstatus_nxt[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
                    mstatus_nxt[MSTATUS_MIE]  = 1'b0;
                end
                KIND_RET: begin
                    mstatus_nxt[MSTATUS_MPP_LO +: 2] = 2'b00;
                    mstatus_nxt[MSTATUS_MIE]  = mstatus[MSTATUS_MPIE];
                    mstatus_nxt[MSTATUS_MPIE] = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= MSTATUS_RESET;
            mepc    <= '0;
            mcause  <= '0;
            mtvec   <= '0;
        end else begin
            mstatus <= mstatus_nxt;
            mepc    <= mepc_nxt;
            mcause  <= mcause_nxt;
            mtvec   <= mtvec_nxt;
        end
    end

    // ****************************************
    // Response.
    // ****************************************
    assign rsp.rd_data = csr_kind ? old_val : '0;
    assign rsp.err     = req.sel && csr_kind && !known;
    assign rsp.jmp     = req.sel && (req.kind == KIND_TRAP || req.kind == KIND_RET);

    // Jump targets use the values before this edge.
    always_comb begin
        case (req.kind)
            KIND_TRAP: rsp.nxtpc = mtvec;
            KIND_RET:  rsp.nxtpc = mepc;
            default:   rsp.nxtpc = '0;
        endcase
    end

endmodule

// ==== hdl/csr_collect.sv ====
`timescale 1ns/10ps

module csr_collect
    import csr_arch_pkg::*;
#(
    parameter int NUM_HARTS = 4,
    localparam int HART_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
    input  logic              clk,
    input  logic              rst,
    csr_rsp_if.sink           rsp [NUM_HARTS],
    input  logic [HART_W-1:0] hart_sel,
    input  logic              bad_hart,
    input  logic              req_fire,
    output logic              rsp_valid,
    output logic [XLEN-1:0]   rd_data,
    output logic              err,
    output logic              jmp,
    output logic [XLEN-1:0]   nxtpc
);

    logic [XLEN-1:0]      rd_vec [NUM_HARTS];
    logic [XLEN-1:0]      pc_vec [NUM_HARTS];
    logic [NUM_HARTS-1:0] err_vec;
    logic [NUM_HARTS-1:0] jmp_vec;

    logic [XLEN-1:0] rd_sel;
    logic [XLEN-1:0] pc_sel;
    logic            err_sel;
    logic            jmp_sel;

    // Flatten the interface array so it can be indexed at run time.
    for (genvar g = 0; g < NUM_HARTS; g++) begin : g_flat
        assign rd_vec[g]  = rsp[g].rd_data;
        assign pc_vec[g]  = rsp[g].nxtpc;
        assign err_vec[g] = rsp[g].err;
        assign jmp_vec[g] = rsp[g].jmp;
    end

    // ****************************************
    // Hart select.
    // ****************************************
    always_comb begin
        if (bad_hart) begin
            rd_sel  = '0;
            pc_sel  = '0;
            err_sel = 1'b1;
            jmp_sel = 1'b0;
        end else begin
            rd_sel  = rd_vec[hart_sel];
            pc_sel  = pc_vec[hart_sel];
            err_sel = err_vec[hart_sel];
            jmp_sel = jmp_vec[hart_sel];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            err       <= 1'b0;
            jmp       <= 1'b0;
        end else begin
            rsp_valid <= req_fire;
            err       <= req_fire && err_sel;
            jmp       <= req_fire && jmp_sel;
        end
        rd_data <= rd_sel; // Payload.
        nxtpc   <= pc_sel;
    end

endmodule

// ==== hdl/csr_cluster.sv ====
`timescale 1ns/10ps

module csr_cluster
    import csr_arch_pkg::*;
    import csr_ctrl_pkg::*;
#(
    parameter int NUM_HARTS = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid,
    input  csr_op_e         op,
    input  logic [7:0]      hart,
    input  logic [11:0]     addr,
    input  logic [XLEN-1:0] rs1,
    input  logic [4:0]      zimm,
    input  logic [XLEN-1:0] cause,
    input  logic [XLEN-1:0] pc,
    output logic            rsp_valid,
    output logic [XLEN-1:0] rd_data,
    output logic            err,
    output logic            jmp,
    output logic [XLEN-1:0] nxtpc
);

    localparam int HART_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

    logic [HART_W-1:0] hart_sel;
    logic              bad_hart;
    logic              req_fire;

    csr_req_if req_if [NUM_HARTS] ();
    csr_rsp_if rsp_if [NUM_HARTS] ();

    // ****************************************
    // Request side.
    // ****************************************
    csr_dispatch #(
        .NUM_HARTS (NUM_HARTS)
    ) i_dispatch (
        .valid    (valid),
        .op       (op),
        .hart     (hart),
        .addr     (addr),
        .rs1      (rs1),
        .zimm     (zimm),
        .cause    (cause),
        .pc       (pc),
        .req      (req_if),
        .hart_sel (hart_sel),
        .bad_hart (bad_hart),
        .req_fire (req_fire)
    );

    // One CSR file per hart.
    for (genvar g = 0; g < NUM_HARTS; g++) begin : g_hart
        hart_csr i_hart (
            .clk (clk),
            .rst (rst),
            .req (req_if[g]),
            .rsp (rsp_if[g])
        );
    end

    // ****************************************
    // Response side.
    // ****************************************
    csr_collect #(
        .NUM_HARTS (NUM_HARTS)
    ) i_collect (
        .clk       (clk),
        .rst       (rst),
        .rsp       (rsp_if),
        .hart_sel  (hart_sel),
        .bad_hart  (bad_hart),
        .req_fire  (req_fire),
        .rsp_valid (rsp_valid),
        .rd_data   (rd_data),
        .err       (err),
        .jmp       (jmp),
        .nxtpc     (nxtpc)
    );

endmodule

// ==== tests/csr_cluster_checker.sv ====
`timescale 1ns/10ps

module csr_cluster_checker (
    input logic clk,
    input logic rst,
    input logic valid,
    input logic rsp_valid,
    input logic err,
    input logic jmp
);

    int fail_count = 0; // Failed assertions so far.

    // ****************************************
    // Response timing.
    // ****************************************
    a_rsp_follows: assert property (@(posedge clk) disable iff (rst) valid |=> rsp_valid)
        else begin
            $error("rsp_valid missing one cycle after valid.");
            fail_count++;
        end

    a_rsp_only: assert property (@(posedge clk) disable iff (rst) !valid |=> !rsp_valid)
        else begin
            $error("rsp_valid without a request.");
            fail_count++;
        end

    a_jmp_valid: assert property (@(posedge clk) disable iff (rst) jmp |-> rsp_valid)
        else begin
            $error("jmp outside a response.");
            fail_count++;
        end

    a_err_jmp: assert property (@(posedge clk) disable iff (rst) !(err && jmp))
        else begin
            $error("err and jmp high together.");
            fail_count++;
        end

    a_rst_idle: assert property (@(posedge clk) rst |=> !rsp_valid)
        else begin
            $error("rsp_valid high in reset.");
            fail_count++;
        end

endmodule

bind csr_cluster csr_cluster_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .valid     (valid),
    .rsp_valid (rsp_valid),
    .err       (err),
    .jmp       (jmp)
);

// ==== tests/csr_cluster_tb.sv ====
`timescale 1ns/10ps

module csr_cluster_tb
    import csr_arch_pkg::*;
    import csr_ctrl_pkg::*;
;

    localparam int RSP_TIMEOUT = 20;
    localparam int NUM_RAND    = 300;

    typedef struct {
        csr_op_e         op;
        logic [7:0]      hart;
        logic [11:0]     addr;
        logic [XLEN-1:0] rs1;
        logic [4:0]      zimm;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rd;
        logic            err;
        logic            jmp;
        logic [XLEN-1:0] nxtpc;
    } entry_t;

    logic            clk;
    logic            rst;
    logic            valid;
    csr_op_e         op;
    logic [7:0]      hart;
    logic [11:0]     addr;
    logic [XLEN-1:0] rs1;
    logic [4:0]      zimm;
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] pc;
    logic            rsp_valid;
    logic [XLEN-1:0] rd_data;
    logic            err;
    logic            jmp;
    logic [XLEN-1:0] nxtpc;

    entry_t          stim_q [$];
    logic [XLEN-1:0] model_csr [4][4]; // Per hart: mstatus, mepc, mcause, mtvec.
    csr_op_e         op_list [8] = '{OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI,
                                     OP_CSRRSI, OP_CSRRCI, OP_TRAP, OP_MRET};
    logic [11:0]     addr_list [5] = '{12'h300, 12'h341, 12'h342, 12'h305, 12'h7c0};

    csr_cluster #(
        .NUM_HARTS (4)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .op        (op),
        .hart      (hart),
        .addr      (addr),
        .rs1       (rs1),
        .zimm      (zimm),
        .cause     (cause),
        .pc        (pc),
        .rsp_valid (rsp_valid),
        .rd_data   (rd_data),
        .err       (err),
        .jmp       (jmp),
        .nxtpc     (nxtpc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // A failed assertion in the bound checker ends the run.
    always @(i_dut.i_checker.fail_count) begin
        if (i_dut.i_checker.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Assertion failure in the response checker.");
        end
    end

    task automatic compare(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    task automatic add(input csr_op_e o, input logic [7:0] h, input logic [11:0] a,
                       input logic [XLEN-1:0] r, input logic [4:0] z,
                       input logic [XLEN-1:0] c, input logic [XLEN-1:0] p,
                       input logic [XLEN-1:0] erd, input logic ee, input logic ej,
                       input logic [XLEN-1:0] epc);
        entry_t e;
        e.op    = o;
        e.hart  = h;
        e.addr  = a;
        e.rs1   = r;
        e.zimm  = z;
        e.cause = c;
        e.pc    = p;
        e.rd    = erd;
        e.err   = ee;
        e.jmp   = ej;
        e.nxtpc = epc;
        stim_q.push_back(e);
    endtask

    // ****************************************
    // Reference model of the hart registers.
    // ****************************************
    function automatic int reg_index(input logic [11:0] a);
        case (a)
            12'h300: return 0;
            12'h341: return 1;
            12'h342: return 2;
            12'h305: return 3;
            default: return -1;
        endcase
    endfunction

    // Fills the expected fields of e and updates the model.
    task automatic model_step(inout entry_t e);
        int              idx;
        logic [XLEN-1:0] opnd;
        logic [XLEN-1:0] old;
        logic [XLEN-1:0] st;
        e.rd    = '0;
        e.err   = 1'b0;
        e.jmp   = 1'b0;
        e.nxtpc = '0;
        idx  = reg_index(e.addr);
        opnd = (e.op inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI}) ? XLEN'(e.zimm) : e.rs1;
        if (e.hart >= 4) begin
            e.err = 1'b1;
        end else if (e.op == OP_TRAP || e.op == OP_MRET) begin
            st    = model_csr[e.hart][0];
            e.jmp = 1'b1;
            if (e.op == OP_TRAP) begin
                e.nxtpc = model_csr[e.hart][3];
                model_csr[e.hart][1] = e.pc;
                model_csr[e.hart][2] = e.cause;
                st[12:11] = 2'b11;
                st[7]     = st[3];
                st[3]     = 1'b0;
            end else begin
                e.nxtpc   = model_csr[e.hart][1];
                st[12:11] = 2'b00;
                st[3]     = st[7];
                st[7]     = 1'b1;
            end
            model_csr[e.hart][0] = st;
        end else if (idx < 0) begin
            e.err = 1'b1;
        end else begin
            old  = model_csr[e.hart][idx];
            e.rd = old;
            case (e.op)
                OP_CSRRW, OP_CSRRWI: model_csr[e.hart][idx] = opnd;
                OP_CSRRS, OP_CSRRSI: model_csr[e.hart][idx] = old | opnd;
                default:             model_csr[e.hart][idx] = old & ~opnd;
            endcase
        end
    endtask

    // Called 10 ns after a rising edge, returns at the same point one cycle later.
    task automatic issue(input entry_t e);
        int n;
        op    = e.op;
        hart  = e.hart;
        addr  = e.addr;
        rs1   = e.rs1;
        zimm  = e.zimm;
        cause = e.cause;
        pc    = e.pc;
        valid = 1'b1;
        @(posedge clk);
        #1;
        n = 0;
        while (!rsp_valid && n < RSP_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!rsp_valid) begin
            $display("Timed out waiting for rsp_valid after a request.");
            $display("SOME TESTS FAILED");
            $fatal(1, "No response.");
        end
        compare("rsp latency", n, 0);
        compare("rd_data", rd_data, e.rd);
        compare("err", err, e.err);
        compare("jmp", jmp, e.jmp);
        compare("nxtpc", nxtpc, e.nxtpc);
        #9;
        valid = 1'b0;
    endtask

    // ****************************************
    // Directed table.
    // ****************************************
    task automatic build_table();
        for (int h = 0; h < 4; h++) begin // Reset values on every hart.
            add(OP_CSRRS, 8'(h), CSR_MSTATUS, 0, 0, 0, 0, 64'ha0001800, 0, 0, 0);
            add(OP_CSRRS, 8'(h), CSR_MEPC, 0, 0, 0, 0, 0, 0, 0, 0);
            add(OP_CSRRS, 8'(h), CSR_MCAUSE, 0, 0, 0, 0, 0, 0, 0, 0);
            add(OP_CSRRS, 8'(h), CSR_MTVEC, 0, 0, 0, 0, 0, 0, 0, 0);
        end
        add(OP_CSRRW,  8'd0, CSR_MTVEC, 64'h1000, 0, 0, 0, 64'h0, 0, 0, 0);
        add(OP_CSRRS,  8'd0, CSR_MTVEC, 64'h00f0, 0, 0, 0, 64'h1000, 0, 0, 0);
        add(OP_CSRRC,  8'd0, CSR_MTVEC, 64'h1000, 0, 0, 0, 64'h10f0, 0, 0, 0);
        add(OP_CSRRS,  8'd0, CSR_MTVEC, 64'h0, 0, 0, 0, 64'h00f0, 0, 0, 0);
        add(OP_CSRRWI, 8'd0, CSR_MCAUSE, 64'h0, 5'h1f, 0, 0, 64'h0, 0, 0, 0);
        add(OP_CSRRCI, 8'd0, CSR_MCAUSE, 64'h0, 5'h03, 0, 0, 64'h1f, 0, 0, 0);
        add(OP_CSRRSI, 8'd0, CSR_MCAUSE, 64'h0, 5'h01, 0, 0, 64'h1c, 0, 0, 0);
        add(OP_CSRRS,  8'd0, CSR_MCAUSE, 64'h0, 0, 0, 0, 64'h1d, 0, 0, 0);
        add(OP_CSRRW,  8'd0, CSR_MTVEC, 64'h8000, 0, 0, 0, 64'h00f0, 0, 0, 0);
        // Trap entry and return.
        add(OP_CSRRSI, 8'd0, CSR_MSTATUS, 64'h0, 5'h08, 0, 0, 64'ha0001800, 0, 0, 0);
        add(OP_TRAP,   8'd0, 12'h0, 64'h0, 0, 64'hb, 64'h400, 64'h0, 0, 1, 64'h8000);
        add(OP_CSRRS,  8'd0, CSR_MEPC, 64'h0, 0, 0, 0, 64'h400, 0, 0, 0);
        add(OP_CSRRS,  8'd0, CSR_MCAUSE, 64'h0, 0, 0, 0, 64'hb, 0, 0, 0);
        add(OP_CSRRS,  8'd0, CSR_MSTATUS, 64'h0, 0, 0, 0, 64'ha0001880, 0, 0, 0);
        add(OP_MRET,   8'd0, 12'h0, 64'h0, 0, 0, 0, 64'h0, 0, 1, 64'h400);
        add(OP_CSRRS,  8'd0, CSR_MSTATUS, 64'h0, 0, 0, 0, 64'ha0000088, 0, 0, 0);
        // Hart independence.
        add(OP_CSRRS,  8'd1, CSR_MTVEC, 64'h0, 0, 0, 0, 64'h0, 0, 0, 0);
        add(OP_CSRRS,  8'd1, CSR_MSTATUS, 64'h0, 0, 0, 0, 64'ha0001800, 0, 0, 0);
        add(OP_CSRRW,  8'd2, CSR_MEPC, 64'h55, 0, 0, 0, 64'h0, 0, 0, 0);
        add(OP_CSRRS,  8'd0, CSR_MEPC, 64'h0, 0, 0, 0, 64'h400, 0, 0, 0);
        add(OP_CSRRS,  8'd3, CSR_MEPC, 64'h0, 0, 0, 0, 64'h0, 0, 0, 0);
        // Errors change nothing.
        add(OP_CSRRW,  8'd0, 12'h7c0, 64'hffff, 0, 0, 0, 64'h0, 1, 0, 0);
        add(OP_CSRRW,  8'd4, CSR_MTVEC, 64'h1234, 0, 0, 0, 64'h0, 1, 0, 0);
        add(OP_TRAP,   8'd200, 12'h0, 64'h0, 0, 64'h1, 64'h2, 64'h0, 1, 0, 0);
        add(OP_CSRRS,  8'd0, CSR_MTVEC, 64'h0, 0, 0, 0, 64'h8000, 0, 0, 0);
        add(OP_CSRRS,  8'd0, CSR_MEPC, 64'h0, 0, 0, 0, 64'h400, 0, 0, 0);
        add(OP_CSRRS,  8'd2, CSR_MEPC, 64'h0, 0, 0, 0, 64'h55, 0, 0, 0);
    endtask

    initial begin
        entry_t e;
        entry_t tmp;
        void'($urandom(32'h979b8f8a));
        rst   = 1'b1;
        valid = 1'b0;
        op    = OP_CSRRW;
        hart  = '0;
        addr  = '0;
        rs1   = '0;
        zimm  = '0;
        cause = '0;
        pc    = '0;
        for (int h = 0; h < 4; h++) begin
            model_csr[h][0] = 64'ha0001800;
            model_csr[h][1] = '0;
            model_csr[h][2] = '0;
            model_csr[h][3] = '0;
        end
        build_table();
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        foreach (stim_q[i]) begin
            tmp = stim_q[i];
            model_step(tmp); // Keeps the model in step for the random phase.
            issue(stim_q[i]);
        end
        // Back-to-back random requests.
        for (int i = 0; i < NUM_RAND; i++) begin
            e.op    = op_list[$urandom % 8];
            e.hart  = 8'($urandom % 6);
            e.addr  = addr_list[$urandom % 5];
            e.rs1   = {$urandom, $urandom};
            e.zimm  = 5'($urandom);
            e.cause = {$urandom, $urandom};
            e.pc    = {$urandom, $urandom};
            model_step(e);
            issue(e);
        end
        @(posedge clk);
        #1;
        compare("rsp_valid", rsp_valid, 0);
        if (i_dut.i_checker.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Assertion failure in the response checker.");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
hdl/csr_arch_pkg.sv
hdl/csr_ctrl_pkg.sv
hdl/csr_req_if.sv
hdl/csr_rsp_if.sv
hdl/csr_dispatch.sv
hdl/hart_csr.sv
hdl/csr_collect.sv
hdl/csr_cluster.sv
tests/csr_cluster_checker.sv
tests/csr_cluster_tb.sv
